// ==== vga_mode_pkg.sv ====
package vga_mode_pkg;

  // a raster coordinate holds any column or row of the supported modes.
  typedef logic [10:0] coord_t;

  // default mode is 640x480 at 60 Hz with a 25.175 MHz pixel clock.
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;

  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 10;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 33;

  // a whole line is 800 clocks and a whole frame is 525 lines.

endpackage

// ==== gfx_shape_pkg.sv ====
package gfx_shape_pkg;

  // red in the top nibble, then green, then blue.
  typedef logic [11:0] color_t;

  typedef enum logic {
    SHAPE_RECT = 1'b0,
    SHAPE_DISC = 1'b1
  } shape_kind_t;

  // the box is inclusive and the writer keeps x0 <= x1 and y0 <= y1.
  typedef struct packed {
    vga_mode_pkg::coord_t x0;
    vga_mode_pkg::coord_t x1;
    vga_mode_pkg::coord_t y0;
    vga_mode_pkg::coord_t y1;
  } rect_desc_t;

  typedef struct packed {
    vga_mode_pkg::coord_t cx;
    vga_mode_pkg::coord_t cy;
    vga_mode_pkg::coord_t radius;
    logic [10:0]          spare; // pads the disc to the rectangle width.
  } disc_desc_t;

  // the kind field selects which view of the geometry word is meaningful.
  typedef union packed {
    rect_desc_t rect;
    disc_desc_t disc;
  } shape_geom_u;

  typedef struct packed {
    shape_kind_t kind;
    color_t      color;
    logic        enable;
    shape_geom_u geom;
  } shape_desc_t;

  localparam int NUM_SHAPES_DEFAULT = 4;

endpackage

// ==== beam_if.sv ====
`timescale 1ns/100ps

interface beam_if;
  import vga_mode_pkg::*;

  coord_t x;
  coord_t y;
  logic   active; // inside the visible window.
  logic   hsync;  // active low.
  logic   vsync;  // active low.

  modport src (
    output x, y, active, hsync, vsync
  );

  // the shape units only look at the position.
  modport shape (
    input x, y
  );

  modport sink (
    input active, hsync, vsync
  );

endinterface

// ==== raster_timing.sv ====
`timescale 1ns/100ps

module raster_timing #(
  parameter int H_ACTIVE = vga_mode_pkg::H_ACTIVE,
  parameter int H_FRONT  = vga_mode_pkg::H_FRONT,
  parameter int H_SYNC   = vga_mode_pkg::H_SYNC,
  parameter int H_BACK   = vga_mode_pkg::H_BACK,
  parameter int V_ACTIVE = vga_mode_pkg::V_ACTIVE,
  parameter int V_FRONT  = vga_mode_pkg::V_FRONT,
  parameter int V_SYNC   = vga_mode_pkg::V_SYNC,
  parameter int V_BACK   = vga_mode_pkg::V_BACK
) (
  input logic pixel_clk,
  input logic rst_n,
  beam_if.src beam
);
  import vga_mode_pkg::*;

  localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START   = H_ACTIVE + H_FRONT;
  localparam int HS_END     = HS_START + H_SYNC;
  localparam int VS_START   = V_ACTIVE + V_FRONT;
  localparam int VS_END     = VS_START + V_SYNC;

  coord_t h_cnt;
  coord_t v_cnt;
  logic   line_end;
  logic   frame_end;

  assign line_end  = (h_cnt == coord_t'(H_TOTAL - 1));
  assign frame_end = (v_cnt == coord_t'(V_TOTAL - 1));

  // the row steps on the same edge that the column wraps.
  always_ff @(posedge pixel_clk) begin
    if (rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      if (frame_end) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign beam.x = h_cnt;
  assign beam.y = v_cnt;

  assign beam.active = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));

  // sync windows sit between the front and back porches.
  assign beam.hsync = !((h_cnt >= coord_t'(HS_START)) && (h_cnt < coord_t'(HS_END)));
  assign beam.vsync = !((v_cnt >= coord_t'(VS_START)) && (v_cnt < coord_t'(VS_END)));

  a_x_range : assert property (
    @(posedge pixel_clk) disable iff (rst_n)
    h_cnt < coord_t'(H_TOTAL)
  ) else $error("raster_timing: column %0d out of line length %0d", h_cnt, H_TOTAL);

  a_y_range : assert property (
    @(posedge pixel_clk) disable iff (rst_n)
    v_cnt < coord_t'(V_TOTAL)
  ) else $error("raster_timing: row %0d out of frame length %0d", v_cnt, V_TOTAL);

endmodule

// ==== shape_unit.sv ====
`timescale 1ns/100ps

module shape_unit #(
  parameter int NUM_SHAPES  = gfx_shape_pkg::NUM_SHAPES_DEFAULT,
  parameter int SHAPE_INDEX = 0
) (
  input  logic                                                pixel_clk,
  input  logic                                                rst_n,
  input  logic                                                shape_we,
  input  logic [((NUM_SHAPES > 1) ? $clog2(NUM_SHAPES) : 1)-1:0] shape_sel,
  input  gfx_shape_pkg::shape_desc_t                          shape_desc,
  beam_if.shape                                               beam,
  output logic                                                hit,
  output gfx_shape_pkg::color_t                               hit_color
);
  import vga_mode_pkg::*;
  import gfx_shape_pkg::*;

  localparam int SEL_W = (NUM_SHAPES > 1) ? $clog2(NUM_SHAPES) : 1;

  shape_desc_t desc_q;
  logic        sel_match;

  coord_t      dx;
  coord_t      dy;
  logic [21:0] dx2;
  logic [21:0] dy2;
  logic [21:0] r2;
  logic [22:0] dist2;
  logic        rect_hit;
  logic        disc_hit;
  logic        shape_hit;

  assign sel_match = shape_we && (shape_sel == SEL_W'(SHAPE_INDEX));

  always_ff @(posedge pixel_clk) begin
    if (rst_n) begin
      desc_q.enable <= 1'b0;
    end else if (sel_match) begin
      desc_q.enable <= shape_desc.enable;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (sel_match) begin
      desc_q.kind  <= shape_desc.kind;
      desc_q.color <= shape_desc.color;
      desc_q.geom  <= shape_desc.geom;
    end
  end

  assign rect_hit = (beam.x >= desc_q.geom.rect.x0) && (beam.x <= desc_q.geom.rect.x1) &&
                    (beam.y >= desc_q.geom.rect.y0) && (beam.y <= desc_q.geom.rect.y1);

  // absolute distances keep the squares unsigned.
  assign dx = (beam.x >= desc_q.geom.disc.cx) ? beam.x - desc_q.geom.disc.cx
                                              : desc_q.geom.disc.cx - beam.x;
  assign dy = (beam.y >= desc_q.geom.disc.cy) ? beam.y - desc_q.geom.disc.cy
                                              : desc_q.geom.disc.cy - beam.y;

  assign dx2   = dx * dx;
  assign dy2   = dy * dy;
  assign r2    = desc_q.geom.disc.radius * desc_q.geom.disc.radius;
  assign dist2 = 23'(dx2) + 23'(dy2);

  assign disc_hit = (dist2 <= {1'b0, r2});

  assign shape_hit = desc_q.enable && ((desc_q.kind == SHAPE_DISC) ? disc_hit : rect_hit);

  always_ff @(posedge pixel_clk) begin
    if (rst_n) begin
      hit <= 1'b0;
    end else begin
      hit <= shape_hit;
    end
  end

  always_ff @(posedge pixel_clk) begin
    hit_color <= desc_q.color;
  end

  a_hit_needs_enable : assert property (
    @(posedge pixel_clk) disable iff (rst_n)
    hit |-> $past(desc_q.enable)
  ) else $error("shape_unit %0d: hit without an enabled descriptor", SHAPE_INDEX);

endmodule

// ==== pixel_compositor.sv ====
`timescale 1ns/100ps

module pixel_compositor #(
  parameter int                    NUM_SHAPES = gfx_shape_pkg::NUM_SHAPES_DEFAULT,
  parameter gfx_shape_pkg::color_t BG_COLOR   = 12'h000
) (
  input  logic                  pixel_clk,
  input  logic                  rst_n,
  beam_if.sink                  beam,
  input  logic [NUM_SHAPES-1:0] hit,
  input  gfx_shape_pkg::color_t hit_color [NUM_SHAPES],
  output logic [3:0]            vga_red,
  output logic [3:0]            vga_grn,
  output logic [3:0]            vga_blu,
  output logic                  vga_hsync,
  output logic                  vga_vsync,
  output logic                  vga_de
);
  import gfx_shape_pkg::*;

  color_t pick;
  color_t color_q;
  logic   active_d1;
  logic   hsync_d1;
  logic   vsync_d1;

  // walking down from the top lets the lowest index overwrite the rest.
  always_comb begin
    pick = BG_COLOR;
    for (int i = NUM_SHAPES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        pick = hit_color[i];
      end
    end
  end

  // first stage lines the beam flags up with the unit results.
  always_ff @(posedge pixel_clk) begin
    if (rst_n) begin
      active_d1 <= 1'b0;
      hsync_d1  <= 1'b1;
      vsync_d1  <= 1'b1;
      vga_de    <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      color_q   <= '0;
    end else begin
      active_d1 <= beam.active;
      hsync_d1  <= beam.hsync;
      vsync_d1  <= beam.vsync;
      vga_de    <= active_d1;
      vga_hsync <= hsync_d1;
      vga_vsync <= vsync_d1;
      color_q   <= active_d1 ? pick : '0; // black in blanking.
    end
  end

  assign {vga_red, vga_grn, vga_blu} = color_q;

  a_black_in_blank : assert property (
    @(posedge pixel_clk) disable iff (rst_n)
    !vga_de |-> (color_q == '0)
  ) else $error("pixel_compositor: colour %h outside the visible window", color_q);

endmodule

// ==== gfx_shapes_top.sv ====
`timescale 1ns/100ps

module gfx_shapes_top #(
  parameter int                    NUM_SHAPES = gfx_shape_pkg::NUM_SHAPES_DEFAULT,
  parameter gfx_shape_pkg::color_t BG_COLOR   = 12'h124,
  parameter int                    H_ACTIVE   = vga_mode_pkg::H_ACTIVE,
  parameter int                    H_FRONT    = vga_mode_pkg::H_FRONT,
  parameter int                    H_SYNC     = vga_mode_pkg::H_SYNC,
  parameter int                    H_BACK     = vga_mode_pkg::H_BACK,
  parameter int                    V_ACTIVE   = vga_mode_pkg::V_ACTIVE,
  parameter int                    V_FRONT    = vga_mode_pkg::V_FRONT,
  parameter int                    V_SYNC     = vga_mode_pkg::V_SYNC,
  parameter int                    V_BACK     = vga_mode_pkg::V_BACK
) (
  input  logic                                                   pixel_clk,
  input  logic                                                   rst_n,
  input  logic                                                   shape_we,
  input  logic [((NUM_SHAPES > 1) ? $clog2(NUM_SHAPES) : 1)-1:0] shape_sel,
  input  gfx_shape_pkg::shape_desc_t                             shape_desc,
  output logic [3:0]                                             vga_red,
  output logic [3:0]                                             vga_grn,
  output logic [3:0]                                             vga_blu,
  output logic                                                   vga_hsync,
  output logic                                                   vga_vsync,
  output logic                                                   vga_de
);
  import gfx_shape_pkg::*;

  logic [NUM_SHAPES-1:0] unit_hit;
  color_t                unit_color [NUM_SHAPES];

  beam_if beam ();

  raster_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) raster_timing_i (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .beam      (beam)
  );

  // every unit sees the same write bus and picks out its own index.
  for (genvar i = 0; i < NUM_SHAPES; i++) begin : g_shape
    shape_unit #(
      .NUM_SHAPES  (NUM_SHAPES),
      .SHAPE_INDEX (i)
    ) shape_unit_i (
      .pixel_clk  (pixel_clk),
      .rst_n      (rst_n),
      .shape_we   (shape_we),
      .shape_sel  (shape_sel),
      .shape_desc (shape_desc),
      .beam       (beam),
      .hit        (unit_hit[i]),
      .hit_color  (unit_color[i])
    );
  end

  pixel_compositor #(
    .NUM_SHAPES (NUM_SHAPES),
    .BG_COLOR   (BG_COLOR)
  ) pixel_compositor_i (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .beam      (beam),
    .hit       (unit_hit),
    .hit_color (unit_color),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_de    (vga_de)
  );

endmodule

// ==== gfx_shapes_tb.sv ====
`timescale 1ns/100ps

module gfx_shapes_tb;
  import vga_mode_pkg::*;
  import gfx_shape_pkg::*;

  localparam int     NUM_SHAPES  = NUM_SHAPES_DEFAULT;
  localparam int     SEL_W       = $clog2(NUM_SHAPES);
  localparam int     H_VIS       = 24;
  localparam int     V_VIS       = 12;
  localparam int     BLANK       = 2; // front porch, sync and back porch on both axes.
  localparam int     LINE_LEN    = H_VIS + 3 * BLANK;
  localparam int     FRAME_LEN   = LINE_LEN * (V_VIS + 3 * BLANK);
  localparam int     CYCLE_LIMIT = 8 * FRAME_LEN + FRAME_LEN / 2;
  localparam color_t BG          = 12'h3a5;

  typedef struct packed {
    logic   de;
    logic   hs;
    logic   vs;
    color_t col;
  } video_t;

  localparam video_t IDLE_VIDEO = {1'b0, 1'b1, 1'b1, 12'h000};

  logic             pixel_clk = 1'b0;
  logic             rst_n;
  logic             shape_we;
  logic [SEL_W-1:0] shape_sel;
  shape_desc_t      shape_desc;
  logic [3:0]       vga_red;
  logic [3:0]       vga_grn;
  logic [3:0]       vga_blu;
  logic             vga_hsync;
  logic             vga_vsync;
  logic             vga_de;
  color_t           rgb;

  int          mx;
  int          my;
  shape_desc_t mdesc [NUM_SHAPES];
  video_t      exp_d1;
  video_t      exp_q;

  string       test_name = "reset";
  int          errors = 0;
  int          test_err_base = 0;
  int          n_tests = 0;
  int          n_failed = 0;
  int          n_checks = 0;
  int          cycles = 0;
  logic [31:0] lcg_state = 32'd86586;

  always #4 pixel_clk = ~pixel_clk;

  gfx_shapes_top #(
    .NUM_SHAPES (NUM_SHAPES),
    .BG_COLOR   (BG),
    .H_ACTIVE   (H_VIS),
    .H_FRONT    (BLANK),
    .H_SYNC     (BLANK),
    .H_BACK     (BLANK),
    .V_ACTIVE   (V_VIS),
    .V_FRONT    (BLANK),
    .V_SYNC     (BLANK),
    .V_BACK     (BLANK)
  ) UUT (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .shape_we   (shape_we),
    .shape_sel  (shape_sel),
    .shape_desc (shape_desc),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_de     (vga_de)
  );

  assign rgb = {vga_red, vga_grn, vga_blu};

  function automatic int next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:15]); // low bits of an LCG cycle too quickly.
  endfunction

  function automatic shape_desc_t make_rect(input color_t col, input int x0, input int x1,
                                            input int y0, input int y1);
    shape_desc_t d;
    d = '0;
    d.kind = SHAPE_RECT;
    d.color = col;
    d.enable = 1'b1;
    d.geom.rect.x0 = coord_t'(x0);
    d.geom.rect.x1 = coord_t'(x1);
    d.geom.rect.y0 = coord_t'(y0);
    d.geom.rect.y1 = coord_t'(y1);
    return d;
  endfunction

  function automatic shape_desc_t make_disc(input color_t col, input int cx, input int cy,
                                            input int r);
    shape_desc_t d;
    d = '0;
    d.kind = SHAPE_DISC;
    d.color = col;
    d.enable = 1'b1;
    d.geom.disc.cx = coord_t'(cx);
    d.geom.disc.cy = coord_t'(cy);
    d.geom.disc.radius = coord_t'(r);
    return d;
  endfunction

  function automatic shape_desc_t random_shape();
    color_t col;
    int     x;
    int     y;
    int     w;
    int     h;
    col = color_t'(next_rand());
    x = next_rand() % H_VIS;
    y = next_rand() % V_VIS;
    w = next_rand() % 10;
    h = next_rand() % 6;
    if (next_rand() % 2 == 1) begin
      return make_disc(col, x, y, w % 6);
    end
    return make_rect(col, x, x + w, y, y + h);
  endfunction

  function automatic logic shape_covers(input shape_desc_t d, input int x, input int y);
    int dx;
    int dy;
    int r;
    if (!d.enable) begin
      return 1'b0;
    end
    if (d.kind == SHAPE_RECT) begin
      return (x >= int'(d.geom.rect.x0)) && (x <= int'(d.geom.rect.x1)) &&
             (y >= int'(d.geom.rect.y0)) && (y <= int'(d.geom.rect.y1));
    end
    dx = x - int'(d.geom.disc.cx);
    dy = y - int'(d.geom.disc.cy);
    r  = int'(d.geom.disc.radius);
    return (dx * dx + dy * dy) <= (r * r);
  endfunction

  // expected video for one beam position, before the two-cycle pipeline.
  function automatic video_t expect_video(input int x, input int y);
    video_t v;
    logic   found;
    found = 1'b0;
    v.de  = (x < H_VIS) && (y < V_VIS);
    v.hs  = !((x >= H_VIS + BLANK) && (x < H_VIS + 2 * BLANK));
    v.vs  = !((y >= V_VIS + BLANK) && (y < V_VIS + 2 * BLANK));
    v.col = BG;
    for (int i = 0; i < NUM_SHAPES; i++) begin
      if (!found && shape_covers(mdesc[i], x, y)) begin
        v.col = mdesc[i].color;
        found = 1'b1;
      end
    end
    if (!v.de) begin
      v.col = '0;
    end
    return v;
  endfunction

  always @(posedge pixel_clk) begin
    if (rst_n) begin
      mx     <= 0;
      my     <= 0;
      exp_d1 <= IDLE_VIDEO;
      exp_q  <= IDLE_VIDEO;
      for (int i = 0; i < NUM_SHAPES; i++) begin
        mdesc[i].enable <= 1'b0;
      end
    end else begin
      exp_d1   <= expect_video(mx, my); // uses the descriptors from before this edge.
      exp_q    <= exp_d1;
      n_checks = n_checks + 1;
      if (mx == LINE_LEN - 1) begin
        mx <= 0;
        my <= (my == V_VIS + 3 * BLANK - 1) ? 0 : my + 1;
      end else begin
        mx <= mx + 1;
      end
      if (shape_we) begin
        mdesc[shape_sel] <= shape_desc;
      end
    end
  end

  always @(posedge pixel_clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without reaching the end of the tests", cycles);
      $display("test failed");
      $finish;
    end
  end

  a_color : assert property (@(posedge pixel_clk) disable iff (rst_n) rgb == exp_q.col)
    else begin
      errors++;
      $display("mismatch %s colour: expected %h, actual %h", test_name,
               $sampled(exp_q.col), $sampled(rgb));
    end

  a_de : assert property (@(posedge pixel_clk) disable iff (rst_n) vga_de == exp_q.de)
    else begin
      errors++;
      $display("mismatch %s de: expected %b, actual %b", test_name,
               $sampled(exp_q.de), $sampled(vga_de));
    end

  a_sync : assert property (@(posedge pixel_clk) disable iff (rst_n)
                            {vga_hsync, vga_vsync} == {exp_q.hs, exp_q.vs})
    else begin
      errors++;
      $display("mismatch %s hsync/vsync: expected %b%b, actual %b%b", test_name,
               $sampled(exp_q.hs), $sampled(exp_q.vs), $sampled(vga_hsync), $sampled(vga_vsync));
    end

  task automatic load_shape(input int idx, input shape_desc_t d);
    @(negedge pixel_clk);
    shape_we   = 1'b1;
    shape_sel  = SEL_W'(idx);
    shape_desc = d;
    @(negedge pixel_clk);
    shape_we   = 1'b0;
  endtask

  // one vsync pulse marks the end of the visible part of each frame.
  task automatic run_frames(input int n);
    repeat (n) @(negedge vga_vsync);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    int n;
    n = errors - test_err_base;
    n_tests++;
    if (n == 0) begin
      $display("%s: ok", test_name);
    end else begin
      n_failed++;
      $display("%s: %0d mismatches", test_name, n);
    end
  endtask

  initial begin
    rst_n      = 1'b1;
    shape_we   = 1'b0;
    shape_sel  = '0;
    shape_desc = '0;
    repeat (4) @(negedge pixel_clk);
    rst_n = 1'b0;

    begin_test("idle_frame");
    run_frames(1);
    end_test();

    begin_test("rect_edges");
    load_shape(0, make_rect(12'hf00, 0, 5, 0, 3));
    run_frames(1);
    load_shape(0, make_rect(12'h0f0, 17, 23, 9, 11));
    run_frames(1);
    end_test();

    begin_test("disc_single");
    load_shape(0, make_disc(12'h00f, 4, 3, 4)); // crosses the top and left edges.
    run_frames(1);
    end_test();

    begin_test("random_overlap");
    repeat (3) begin
      for (int i = 0; i < NUM_SHAPES; i++) begin
        load_shape(i, random_shape());
      end
      run_frames(1);
    end
    end_test();

    begin_test("mid_frame_update");
    for (int i = 1; i < NUM_SHAPES; i++) begin
      load_shape(i, '0);
    end
    load_shape(0, make_rect(12'hfff, 0, H_VIS - 1, 0, V_VIS - 1));
    repeat (4) @(posedge vga_de);
    repeat (7) @(negedge pixel_clk);
    load_shape(0, make_disc(12'hc3c, 12, 6, 5));
    repeat (3) @(posedge vga_de);
    repeat (11) @(negedge pixel_clk);
    load_shape(0, '0);
    run_frames(1);
    end_test();

    @(negedge pixel_clk);
    $display("%0d tests, %0d failed, %0d pixels checked, %0d mismatches",
             n_tests, n_failed, n_checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
vga_mode_pkg.sv
gfx_shape_pkg.sv
beam_if.sv
raster_timing.sv
shape_unit.sv
pixel_compositor.sv
gfx_shapes_top.sv
gfx_shapes_tb.sv

// ==== Bender.yml ====
package:
  name: gfx_shapes

sources:
  - files:
      - vga_mode_pkg.sv
      - gfx_shape_pkg.sv
      - beam_if.sv
      - raster_timing.sv
      - shape_unit.sv
      - pixel_compositor.sv
      - gfx_shapes_top.sv
  - target: simulation
    files:
      - gfx_shapes_tb.sv
